// ==== design/regdec_pkg.sv ====
`default_nettype none

package regdec_pkg;

   ////////////////////
   // Widths

   // The chain halves at each level, so the word is a power of two
   localparam int WORD_LEVELS = 3;
   localparam int WORD_W      = 2 ** WORD_LEVELS;
   localparam int AMOUNT_W    = 4;

   typedef logic [WORD_W-1:0]   word_t;
   typedef logic [AMOUNT_W-1:0] amount_t;

   ////////////////////
   // Control encodings

   // Same ordering as the cell mux inputs: own bit, load, neighbour, zero
   typedef enum logic [1:0] {
      OP_HOLD  = 2'b00,
      OP_LOAD  = 2'b01,
      OP_SHIFT = 2'b10,
      OP_CLEAR = 2'b11
   } cell_op_t;

   typedef enum logic {
      DIR_LEFT  = 1'b0,
      DIR_RIGHT = 1'b1
   } dir_t;

   typedef struct packed {
      dir_t     dir;
      cell_op_t op;
   } seq_ctrl_t;

   typedef enum logic {
      CMD_SHIFT = 1'b0,
      CMD_CLEAR = 1'b1
   } cmd_kind_t;

   typedef struct packed {
      cmd_kind_t kind;
      dir_t      dir;
      logic      fill;
      amount_t   amount;
      word_t     data;
   } shift_cmd_t;

   typedef enum logic [1:0] {
      IDLE,
      LOAD,
      SHIFT,
      DONE
   } seq_state_t;

endpackage

`default_nettype wire

// ==== design/regdec_cell.sv ====
`timescale 1ns/100ps
`default_nettype none

module regdec_cell
   import regdec_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  cell_op_t op,
   input  logic     load_bit,
   input  logic     propagator,
   output logic     q
);

   logic next_bit;

   // Four-way selector in front of the flip-flop
   always_comb
   begin
      case (op)
         OP_LOAD:  next_bit = load_bit;
         OP_SHIFT: next_bit = propagator;
         OP_CLEAR: next_bit = 1'b0;
         default:  next_bit = q;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         q <= 1'b0;
      else
         q <= next_bit;
   end

endmodule

`default_nettype wire

// ==== design/regdec_chain.sv ====
`timescale 1ns/100ps
`default_nettype none

module regdec_chain
   import regdec_pkg::*;
#(
   parameter int LEVELS = WORD_LEVELS
)
(
   input  logic                   clk,
   input  logic                   reset,
   input  cell_op_t               op,
   input  logic [2**LEVELS-1:0]   load_bits,
   input  logic                   propagator,
   output logic [2**LEVELS-1:0]   q
);

   localparam int HALF = 2 ** (LEVELS - 1);

   if (LEVELS == 1)
   begin : g_pair
      // Bottom cell sees the outside propagator, the top cell sees the bottom one
      regdec_cell u_cell_lo (
         .clk        (clk),
         .reset      (reset),
         .op         (op),
         .load_bit   (load_bits[0]),
         .propagator (propagator),
         .q          (q[0])
      );

      regdec_cell u_cell_hi (
         .clk        (clk),
         .reset      (reset),
         .op         (op),
         .load_bit   (load_bits[1]),
         .propagator (q[0]),
         .q          (q[1])
      );
   end
   else
   begin : g_split
      regdec_chain #(.LEVELS(LEVELS - 1)) u_lo (
         .clk        (clk),
         .reset      (reset),
         .op         (op),
         .load_bits  (load_bits[HALF-1:0]),
         .propagator (propagator),
         .q          (q[HALF-1:0])
      );

      // Upper half is fed by the top bit of the lower half
      regdec_chain #(.LEVELS(LEVELS - 1)) u_hi (
         .clk        (clk),
         .reset      (reset),
         .op         (op),
         .load_bits  (load_bits[2*HALF-1:HALF]),
         .propagator (q[HALF-1]),
         .q          (q[2*HALF-1:HALF])
      );
   end

endmodule

`default_nettype wire

// ==== design/regdec_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none

module regdec_shifter
   import regdec_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  seq_ctrl_t ctrl,
   input  word_t     data,
   input  logic      fill,
   output word_t     word
);

   word_t chain_in;
   word_t chain_out;

   ////////////////////
   // Orientation

   // The chain only moves bits upward, so a right shift runs on the mirrored word
   always_comb
   begin
      if (ctrl.dir == DIR_RIGHT)
      begin
         chain_in = {<<{data}};
         word     = {<<{chain_out}};
      end
      else
      begin
         chain_in = data;
         word     = chain_out;
      end
   end

   ////////////////////
   // Register chain

   // Fill is a single bit, so mirroring leaves it as is; it always enters at the bottom
   regdec_chain #(.LEVELS(WORD_LEVELS)) u_chain (
      .clk        (clk),
      .reset      (reset),
      .op         (ctrl.op),
      .load_bits  (chain_in),
      .propagator (fill),
      .q          (chain_out)
   );

endmodule

`default_nettype wire

// ==== design/regdec_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module regdec_sequencer
   import regdec_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       start,
   input  shift_cmd_t cmd,
   output seq_ctrl_t  ctrl,
   output word_t      data,
   output logic       fill,
   output logic       busy,
   output logic       done
);

   seq_state_t state_q;
   seq_state_t state_d;
   cmd_kind_t  kind_q;
   dir_t       dir_q;
   amount_t    count_q;
   amount_t    steps;
   word_t      data_q;
   logic       fill_q;
   logic       accept;

   assign busy   = (state_q == LOAD) || (state_q == SHIFT);
   assign accept = start && !busy;
   assign done   = (state_q == DONE);
   assign data   = data_q;
   assign fill   = fill_q;

   // Beyond the word width only fill is left, so stop counting there
   assign steps = (cmd.amount > amount_t'(WORD_W)) ? amount_t'(WORD_W) : cmd.amount;

   ////////////////////
   // FSM

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (accept)
               state_d = LOAD;
         end
         LOAD:
         begin
            if (kind_q == CMD_CLEAR || count_q == '0)
               state_d = DONE;
            else
               state_d = SHIFT;
         end
         SHIFT:
         begin
            if (count_q == amount_t'(1))
               state_d = DONE;
         end
         default:
         begin
            state_d = accept ? LOAD : IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state_q <= IDLE;
         kind_q  <= CMD_SHIFT;
         dir_q   <= DIR_LEFT;
         count_q <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (accept)
         begin
            kind_q  <= cmd.kind;
            count_q <= steps;
            // A clear leaves the orientation alone so the zero word is not mirrored
            if (cmd.kind == CMD_SHIFT)
               dir_q <= cmd.dir;
         end
         else if (state_q == SHIFT)
            count_q <= count_q - amount_t'(1);
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         data_q <= cmd.data;
         fill_q <= cmd.fill;
      end
   end

   always_comb
   begin
      ctrl.dir = dir_q;
      case (state_q)
         LOAD:    ctrl.op = (kind_q == CMD_CLEAR) ? OP_CLEAR : OP_LOAD;
         SHIFT:   ctrl.op = OP_SHIFT;
         default: ctrl.op = OP_HOLD;
      endcase
   end

   ////////////////////
   // Checks

   a_done_single : assert property (@(posedge clk) disable iff (reset)
      done |=> !done);

   a_count_live : assert property (@(posedge clk) disable iff (reset)
      (state_q == SHIFT) |-> (count_q != '0));

   a_idle_hold : assert property (@(posedge clk) disable iff (reset)
      !busy |-> (ctrl.op == OP_HOLD));

endmodule

`default_nettype wire

// ==== design/regdec_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module regdec_top
   import regdec_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       start,
   input  shift_cmd_t cmd,
   output logic       busy,
   output logic       done,
   output word_t      result
);

   seq_ctrl_t ctrl;
   word_t     seq_data;
   logic      seq_fill;

   regdec_sequencer u_sequencer (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .cmd   (cmd),
      .ctrl  (ctrl),
      .data  (seq_data),
      .fill  (seq_fill),
      .busy  (busy),
      .done  (done)
   );

   // Result comes straight off the register, valid while done is high
   regdec_shifter u_shifter (
      .clk   (clk),
      .reset (reset),
      .ctrl  (ctrl),
      .data  (seq_data),
      .fill  (seq_fill),
      .word  (result)
   );

endmodule

`default_nettype wire

// ==== tests/regdec_ref.svh ====
`ifndef REGDEC_REF_SVH
`define REGDEC_REF_SVH

// Expected register contents once a command has completed
function automatic word_t expected_word(input shift_cmd_t c);
   word_t w;
   int    i;
   w = c.data;
   if (c.kind == CMD_CLEAR)
      w = '0;
   else
   begin
      // One place per step, the fill bit entering at the vacated end
      for (i = 0; i < int'(c.amount); i++)
      begin
         if (c.dir == DIR_LEFT)
            w = {w[WORD_W-2:0], c.fill};
         else
            w = {c.fill, w[WORD_W-1:1]};
      end
   end
   return w;
endfunction

`endif

// ==== tests/regdec_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module regdec_tb
   import regdec_pkg::*;
();

   localparam int NUM_RANDOM   = 40;
   localparam int NUM_DIRECTED = 8;
   localparam int NUM_COMMANDS = NUM_RANDOM + NUM_DIRECTED;
   localparam int CYCLE_LIMIT  = NUM_COMMANDS * 12 + 50;
   localparam logic [31:0] LFSR_SEED = 32'hb959_a171;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   logic       clk = 1'b0;
   logic       reset;
   logic       start;
   shift_cmd_t cmd;
   logic       busy;
   logic       done;
   word_t      result;

   int          cycle_count    = 0;
   int          mismatch_count = 0;
   int          failure_count  = 0;
   int          accepted_count = 0;
   int          done_count     = 0;
   logic        prev_done      = 1'b0;
   logic [31:0] lfsr_state     = LFSR_SEED;

   // One entry per accepted command, oldest first
   word_t exp_word_q[$];
   int    exp_lat_q[$];
   int    exp_cycle_q[$];

   `include "regdec_ref.svh"

   regdec_top DUT (
      .clk    (clk),
      .reset  (reset),
      .start  (start),
      .cmd    (cmd),
      .busy   (busy),
      .done   (done),
      .result (result)
   );

   always #20 clk = ~clk;

   always @(posedge clk)
      cycle_count <= cycle_count + 1;

   ////////////////////
   // Helpers

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic shift_cmd_t make_shift(input dir_t d, input logic f, input amount_t a,
                                             input word_t w);
      shift_cmd_t c;
      c.kind   = CMD_SHIFT;
      c.dir    = d;
      c.fill   = f;
      c.amount = a;
      c.data   = w;
      return c;
   endfunction

   function automatic shift_cmd_t make_clear();
      shift_cmd_t c;
      c        = make_shift(DIR_RIGHT, 1'b1, amount_t'(3), 8'h3c);
      c.kind   = CMD_CLEAR;
      return c;
   endfunction

   function automatic shift_cmd_t random_command();
      logic [31:0] r;
      dir_t        d;
      logic        f;
      amount_t     a;
      r = take_bits(1);
      d = r[0] ? DIR_RIGHT : DIR_LEFT;
      r = take_bits(1);
      f = r[0];
      r = take_bits(4);
      a = amount_t'(r % 9);
      r = take_bits(WORD_W);
      return make_shift(d, f, a, word_t'(r));
   endfunction

   // Edges from acceptance to the edge that raises done
   function automatic int expected_latency(input shift_cmd_t c);
      if (c.kind == CMD_CLEAR)
         return 1;
      if (int'(c.amount) > WORD_W)
         return WORD_W + 1;
      return int'(c.amount) + 1;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected)
      begin
         $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
         mismatch_count++;
      end
   endtask

   task automatic wait_idle();
      while (busy)
         @(negedge clk);
   endtask

   // Called on a falling edge; with hammer set, start is held high while busy
   task automatic issue_command(input shift_cmd_t c, input logic hammer);
      wait_idle();
      start = 1'b1;
      cmd   = c;
      exp_word_q.push_back(expected_word(c));
      exp_lat_q.push_back(expected_latency(c));
      exp_cycle_q.push_back(cycle_count + 1);
      accepted_count++;
      @(negedge clk);
      start = 1'b0;
      if (hammer)
      begin
         while (busy)
         begin
            start = 1'b1;
            cmd   = random_command();
            @(negedge clk);
         end
         start = 1'b0;
      end
   endtask

   ////////////////////
   // Stimulus

   initial
   begin
      shift_cmd_t  c;
      logic [31:0] r;
      int          i;
      reset = 1'b1;
      start = 1'b0;
      cmd   = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check_value("busy", busy, 0);
      check_value("done", done, 0);
      check_value("result", result, 0);

      issue_command(make_shift(DIR_LEFT, 1'b0, amount_t'(0), 8'ha5), 1'b0);
      issue_command(make_clear(), 1'b0);
      issue_command(make_shift(DIR_RIGHT, 1'b1, amount_t'(3), 8'h3c), 1'b0);
      issue_command(make_clear(), 1'b0);
      issue_command(make_shift(DIR_LEFT, 1'b0, amount_t'(8), 8'hff), 1'b0);
      issue_command(make_shift(DIR_RIGHT, 1'b1, amount_t'(12), 8'h00), 1'b0);
      issue_command(make_shift(DIR_LEFT, 1'b1, amount_t'(5), 8'h81), 1'b1);
      issue_command(make_shift(DIR_RIGHT, 1'b0, amount_t'(2), 8'h5a), 1'b1);

      // Without a gap the next command lands in the done cycle
      for (i = 0; i < NUM_RANDOM; i++)
      begin
         r = take_bits(1);
         wait_idle();
         repeat (r) @(negedge clk);
         c = random_command();
         r = take_bits(3);
         issue_command(c, r == 0);
      end

      while (exp_word_q.size() != 0)
         @(negedge clk);
      repeat (2) @(negedge clk);
      check_value("done pulse count", done_count, accepted_count);
      $display("Report: %0d mismatches, %0d other errors, %0d commands, %0d done pulses",
               mismatch_count, failure_count, accepted_count, done_count);
      if (mismatch_count == 0 && failure_count == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   ////////////////////
   // Compare

   initial
   begin
      word_t w;
      int    lat;
      int    acc;
      forever
      begin
         @(negedge clk);
         if (!reset)
         begin
            if (done)
            begin
               done_count++;
               // A new command must be accepted in the done cycle
               check_value("busy", busy, 0);
               if (prev_done)
               begin
                  $display("ERROR: done stayed high for two cycles in a row at %0t", $time);
                  failure_count++;
               end
               if (exp_word_q.size() == 0)
               begin
                  $display("ERROR: done pulse with no command outstanding at %0t", $time);
                  failure_count++;
               end
               else
               begin
                  w   = exp_word_q.pop_front();
                  lat = exp_lat_q.pop_front();
                  acc = exp_cycle_q.pop_front();
                  check_value("result", result, w);
                  check_value("done latency", cycle_count - acc, lat);
               end
            end
            prev_done = done;
         end
      end
   end

   initial
   begin
      wait (cycle_count >= CYCLE_LIMIT);
      $display("ERROR: timeout after %0d cycles, done never came for a command", cycle_count);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tests
design/regdec_pkg.sv
design/regdec_cell.sv
design/regdec_chain.sv
design/regdec_shifter.sv
design/regdec_sequencer.sv
design/regdec_top.sv
tests/regdec_tb.sv

// ==== Bender.yml ====
package:
  name: regdec

sources:
  - files:
      - design/regdec_pkg.sv
      - design/regdec_cell.sv
      - design/regdec_chain.sv
      - design/regdec_shifter.sv
      - design/regdec_sequencer.sv
      - design/regdec_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/regdec_tb.sv
